/* source/div_pkg.sv */
//--------------------------------------------------------------------------
// iterative divider shared definitions
// division kind, APB register map and control/status bit positions
//--------------------------------------------------------------------------
package div_pkg;

  // division kind, carried with every request and latched for the datapath
  typedef enum logic [0:0] {
    div_unsigned = 1'b0,
    div_signed   = 1'b1
  } div_op_e;

  //------------------------------------------------------------------------
  // register byte offsets
  //------------------------------------------------------------------------
  // operands, written by software before a start
  localparam logic [7:0] reg_opa    = 8'h00;
  localparam logic [7:0] reg_opb    = 8'h04;
  // start and signed select
  localparam logic [7:0] reg_ctrl   = 8'h08;
  // busy and done, read only
  localparam logic [7:0] reg_status = 8'h0C;
  // results held by the output buffer
  localparam logic [7:0] reg_quot   = 8'h10;
  localparam logic [7:0] reg_rem    = 8'h14;

  //------------------------------------------------------------------------
  // bit positions
  //------------------------------------------------------------------------
  // control word, start is self clearing and reads back as zero
  localparam int ctrl_start_bit  = 0;
  localparam int ctrl_signed_bit = 1;

  // status word
  localparam int status_busy_bit = 0;
  localparam int status_done_bit = 1;

endpackage

/* source/div_req_if.sv */
//--------------------------------------------------------------------------
// divide request channel, APB front end to the divider
//--------------------------------------------------------------------------
`timescale 1ns/1ps

interface div_req_if #(
  parameter int WIDTH = 32
);
  import div_pkg::*;

  // payload, stable from val rising until the transfer
  div_op_e          op;
  logic [WIDTH-1:0] a;
  logic [WIDTH-1:0] b;
  // handshake
  logic             val;
  logic             rdy;

  modport requester (output op, output a, output b, output val, input rdy);
  // control unit sees only the handshake and the op
  modport responder (input op, input val, output rdy);
  // datapath samples the operands when told to load
  modport operand (input a, input b);

endinterface

/* source/div_resp_if.sv */
//--------------------------------------------------------------------------
// divide response channel, divider to the result buffer
//--------------------------------------------------------------------------
`timescale 1ns/1ps

interface div_resp_if #(
  parameter int WIDTH = 32
);

  logic [WIDTH-1:0] quot;
  logic [WIDTH-1:0] rem;
  logic             val;
  logic             rdy;

  // val/rdy from the control unit, data from the datapath
  modport source (output val, input rdy);
  modport data (output quot, output rem);
  modport sink (input quot, input rem, input val, output rdy);

endinterface

/* source/div_ctrl_if.sv */
//--------------------------------------------------------------------------
// divider control unit to datapath lines
//--------------------------------------------------------------------------
`timescale 1ns/1ps

interface div_ctrl_if;
  import div_pkg::*;

  // capture operands and signs, single cycle
  logic    load;
  // one shift-and-subtract iteration
  logic    step;
  // op of the running division
  // follows the request while idle so load sees it
  div_op_e op;

  modport controller (output load, output step, output op);
  modport datapath (input load, input step, input op);

endinterface

/* source/div_apb_regs.sv */
//--------------------------------------------------------------------------
// divider APB register block
// operand and control registers, start issue, busy tracking, read mux
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module div_apb_regs #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  logic [7:0]       paddr,
  input  logic [WIDTH-1:0] pwdata,
  output logic [WIDTH-1:0] prdata,
  output logic             pready,
  output logic             pslverr,
  div_req_if.requester     req,
  input  logic [WIDTH-1:0] buf_quot,
  input  logic [WIDTH-1:0] buf_rem,
  input  logic             buf_done,
  output logic             buf_clear
);
  import div_pkg::*;

  logic [WIDTH-1:0] opa_q;
  logic [WIDTH-1:0] opb_q;
  logic             signed_q;
  logic             val_q;
  logic             busy_q;
  logic             busy;
  logic             wr_acc;
  logic             ctrl_wr;
  logic             start_req;
  logic             start_ok;

  //------------------------------------------------------------------------
  // access decode
  //------------------------------------------------------------------------
  // access phase, no wait states
  assign wr_acc    = psel & penable & pwrite;
  assign ctrl_wr   = wr_acc & (paddr == reg_ctrl);
  assign start_req = ctrl_wr & pwdata[ctrl_start_bit];

  // busy_q lags done by one edge, mask it so busy drops with done rising
  assign busy     = busy_q & ~buf_done;
  assign start_ok = start_req & ~busy;
  // start while a division runs is refused
  assign pslverr  = start_req & busy;
  assign pready   = 1'b1;

  // accepted start empties the result buffer at the same edge
  assign buf_clear = start_ok;

  // operand registers, plain payload
  always_ff @(posedge clk) begin
    if (wr_acc && paddr == reg_opa) begin
      opa_q <= pwdata;
    end
    if (wr_acc && paddr == reg_opb) begin
      opb_q <= pwdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      signed_q <= 1'b0;
      val_q    <= 1'b0;
      busy_q   <= 1'b0;
    end else begin
      // refused write leaves the signed select alone
      if (ctrl_wr && !pslverr) begin
        signed_q <= pwdata[ctrl_signed_bit];
      end
      // request held until the divider takes it
      if (start_ok) begin
        val_q <= 1'b1;
      end else if (val_q && req.rdy) begin
        val_q <= 1'b0;
      end
      // busy from start until the buffer reports done
      if (start_ok) begin
        busy_q <= 1'b1;
      end else if (buf_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // request payload straight from the registers
  assign req.op  = div_op_e'(signed_q);
  assign req.a   = opa_q;
  assign req.b   = opb_q;
  assign req.val = val_q;

  //------------------------------------------------------------------------
  // read mux
  //------------------------------------------------------------------------
  // unmapped offsets read zero
  always_comb begin
    prdata = '0;
    case (paddr)
      reg_opa:    prdata = opa_q;
      reg_opb:    prdata = opb_q;
      reg_ctrl:   prdata[ctrl_signed_bit] = signed_q;
      reg_status: begin
        prdata[status_busy_bit] = busy;
        prdata[status_done_bit] = buf_done;
      end
      reg_quot:   prdata = buf_quot;
      reg_rem:    prdata = buf_rem;
      default:    prdata = '0;
    endcase
  end

endmodule

/* source/div_iter_ctrl.sv */
//--------------------------------------------------------------------------
// divider control unit
// idle/calculate/done sequencing with a WIDTH step counter
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module div_iter_ctrl #(
  parameter int WIDTH = 32
) (
  input  logic           clk,
  input  logic           reset,
  div_req_if.responder   req,
  div_resp_if.source     resp,
  div_ctrl_if.controller ctl
);
  import div_pkg::*;

  // counter runs 0 .. WIDTH-1, one quotient bit each
  localparam int cnt_w = $clog2(WIDTH);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(WIDTH - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  state_e           state;
  logic [cnt_w-1:0] cnt;
  div_op_e          op_q;
  logic             accept;
  logic             send;

  // handshakes on both channels
  assign accept = req.val & req.rdy;
  assign send   = resp.val & resp.rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
      op_q  <= div_unsigned;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_calc;
            cnt   <= '0;
            op_q  <= req.op;
          end
        end
        // exactly WIDTH calculate cycles
        st_calc: begin
          if (cnt == cnt_last) begin
            state <= st_done;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        // result held until the buffer takes it
        st_done: begin
          if (send) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // every output is a function of state, no defaults to fall through
  assign req.rdy  = (state == st_idle);
  assign resp.val = (state == st_done);
  assign ctl.load = (state == st_idle) & req.val;
  assign ctl.step = (state == st_calc);
  // pass the request op through while idle so load converts correctly
  assign ctl.op   = (state == st_idle) ? req.op : op_q;

endmodule

/* source/div_iter_dpath.sv */
//--------------------------------------------------------------------------
// divider datapath
// operand magnitudes, restoring shift-and-subtract, sign fix-up
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module div_iter_dpath #(
  parameter int WIDTH = 32
) (
  input  logic         clk,
  input  logic         reset,
  div_req_if.operand   req,
  div_ctrl_if.datapath ctl,
  div_resp_if.data     resp
);
  import div_pkg::*;

  // working register holds {guard, remainder, quotient}
  logic [2*WIDTH:0] work_q;
  // divisor magnitude aligned with the remainder half
  logic [2*WIDTH:0] dvsr_q;
  logic             sign_a_q;
  logic             sign_b_q;

  logic             is_signed;
  logic             neg_a;
  logic             neg_b;
  logic [WIDTH-1:0] mag_a;
  logic [WIDTH-1:0] mag_b;
  logic [2*WIDTH:0] shifted;
  logic [2*WIDTH:0] diff;
  logic [2*WIDTH:0] work_next;
  logic [WIDTH-1:0] quot_mag;
  logic [WIDTH-1:0] rem_mag;

  //------------------------------------------------------------------------
  // operand conversion
  //------------------------------------------------------------------------
  // sign bits only count for a signed division
  assign is_signed = (ctl.op == div_signed);
  assign neg_a     = is_signed & req.a[WIDTH-1];
  assign neg_b     = is_signed & req.b[WIDTH-1];
  // most negative value stays as its own magnitude, read unsigned
  assign mag_a     = neg_a ? (~req.a + 1'b1) : req.a;
  assign mag_b     = neg_b ? (~req.b + 1'b1) : req.b;

  //------------------------------------------------------------------------
  // one restoring step
  //------------------------------------------------------------------------
  assign shifted = work_q << 1;
  assign diff    = shifted - dvsr_q;

  // guard bit set means the subtract went negative, restore
  always_comb begin
    if (diff[2*WIDTH]) begin
      work_next = {shifted[2*WIDTH:1], 1'b0};
    end else begin
      work_next = {diff[2*WIDTH:1], 1'b1};
    end
  end

  // working registers are payload
  always_ff @(posedge clk) begin
    if (ctl.load) begin
      work_q <= {{(WIDTH + 1){1'b0}}, mag_a};
      dvsr_q <= {1'b0, mag_b, {WIDTH{1'b0}}};
    end else if (ctl.step) begin
      work_q <= work_next;
    end
  end

  // signs already qualified by op
  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a_q <= 1'b0;
      sign_b_q <= 1'b0;
    end else if (ctl.load) begin
      sign_a_q <= neg_a;
      sign_b_q <= neg_b;
    end
  end

  //------------------------------------------------------------------------
  // result fix-up
  //------------------------------------------------------------------------
  assign quot_mag = work_q[WIDTH-1:0];
  assign rem_mag  = work_q[2*WIDTH-1:WIDTH];

  // quotient negative when the signs differ
  assign resp.quot = (sign_a_q ^ sign_b_q) ? (~quot_mag + 1'b1) : quot_mag;
  // remainder takes the sign of the dividend
  assign resp.rem  = sign_a_q ? (~rem_mag + 1'b1) : rem_mag;

endmodule

/* source/div_result_buf.sv */
//--------------------------------------------------------------------------
// divider result buffer
// single entry for quotient and remainder, emptied by a new start
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module div_result_buf #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             reset,
  div_resp_if.sink         resp,
  input  logic             clear,
  output logic [WIDTH-1:0] quot,
  output logic [WIDTH-1:0] rem,
  output logic             done
);

  logic             full_q;
  logic [WIDTH-1:0] quot_q;
  logic [WIDTH-1:0] rem_q;
  logic             capture;

  // take a response only when empty
  assign resp.rdy = ~full_q;
  assign capture  = resp.val & resp.rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (clear) begin
      full_q <= 1'b0;
    end else if (capture) begin
      full_q <= 1'b1;
    end
  end

  // holding registers keep the last result until overwritten
  always_ff @(posedge clk) begin
    if (capture) begin
      quot_q <= resp.quot;
      rem_q  <= resp.rem;
    end
  end

  assign quot = quot_q;
  assign rem  = rem_q;
  assign done = full_q;

endmodule

/* source/div_apb_top.sv */
//--------------------------------------------------------------------------
// APB iterative divider top level
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module div_apb_top #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  logic [7:0]       paddr,
  input  logic [WIDTH-1:0] pwdata,
  output logic [WIDTH-1:0] prdata,
  output logic             pready,
  output logic             pslverr
);

  // buffer to register block
  logic [WIDTH-1:0] buf_quot;
  logic [WIDTH-1:0] buf_rem;
  logic             buf_done;
  logic             buf_clear;

  div_req_if #(.WIDTH(WIDTH)) req_if ();
  div_resp_if #(.WIDTH(WIDTH)) resp_if ();
  div_ctrl_if ctl_if ();

  div_apb_regs #(
    .WIDTH (WIDTH)
  ) u_regs (
    .clk       (clk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .req       (req_if.requester),
    .buf_quot  (buf_quot),
    .buf_rem   (buf_rem),
    .buf_done  (buf_done),
    .buf_clear (buf_clear)
  );

  div_iter_ctrl #(
    .WIDTH (WIDTH)
  ) u_ctrl (
    .clk   (clk),
    .reset (reset),
    .req   (req_if.responder),
    .resp  (resp_if.source),
    .ctl   (ctl_if.controller)
  );

  div_iter_dpath #(
    .WIDTH (WIDTH)
  ) u_dpath (
    .clk   (clk),
    .reset (reset),
    .req   (req_if.operand),
    .ctl   (ctl_if.datapath),
    .resp  (resp_if.data)
  );

  div_result_buf #(
    .WIDTH (WIDTH)
  ) u_buf (
    .clk   (clk),
    .reset (reset),
    .resp  (resp_if.sink),
    .clear (buf_clear),
    .quot  (buf_quot),
    .rem   (buf_rem),
    .done  (buf_done)
  );

endmodule

/* verif/div_tb.sv */
//--------------------------------------------------------------------------
// testbench for the APB iterative divider
// directed and random divisions checked against a reference model
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module div_tb;
  import div_pkg::*;

  localparam int WIDTH = 32;
  // status reads per operation before giving up
  localparam int max_polls = 100;

  logic             clk;
  logic             reset;
  logic             psel;
  logic             penable;
  logic             pwrite;
  logic [7:0]       paddr;
  logic [WIDTH-1:0] pwdata;
  logic [WIDTH-1:0] prdata;
  logic             pready;
  logic             pslverr;

  // results waiting for the compare process as {quot, rem}
  logic [2*WIDTH-1:0] got_q[$];
  logic [2*WIDTH-1:0] exp_q[$];
  string              tag_q[$];
  event               result_ready;

  integer seed;
  int     err_count;
  int     test_count;
  int     fail_count;
  int     test_errs;
  string  cur_test;

  div_apb_top #(
    .WIDTH (WIDTH)
  ) dut (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  // 100 ns period
  always #50 clk = ~clk;

  //--------------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------------
  // divide magnitudes, then quotient sign from both operands, remainder from the dividend
  function automatic logic [2*WIDTH-1:0] ref_div(input logic [WIDTH-1:0] a,
                                                 input logic [WIDTH-1:0] b,
                                                 input logic is_signed);
    logic             neg_a;
    logic             neg_b;
    logic [WIDTH-1:0] mag_a;
    logic [WIDTH-1:0] mag_b;
    logic [WIDTH-1:0] q;
    logic [WIDTH-1:0] r;
    neg_a = is_signed & a[WIDTH-1];
    neg_b = is_signed & b[WIDTH-1];
    mag_a = neg_a ? -a : a;
    mag_b = neg_b ? -b : b;
    // zero divisor gives an all ones quotient and keeps the dividend as remainder
    if (mag_b == '0) begin
      q = '1;
      r = mag_a;
    end else begin
      q = mag_a / mag_b;
      r = mag_a % mag_b;
    end
    if (neg_a ^ neg_b) begin
      q = -q;
    end
    if (neg_a) begin
      r = -r;
    end
    return {q, r};
  endfunction

  // compare process drains everything queued so far
  always @(result_ready) begin : compare_results
    logic [2*WIDTH-1:0] got;
    logic [2*WIDTH-1:0] exp;
    string              tag;
    while (got_q.size() > 0) begin
      got = got_q.pop_front();
      exp = exp_q.pop_front();
      tag = tag_q.pop_front();
      if (got[2*WIDTH-1:WIDTH] !== exp[2*WIDTH-1:WIDTH]) begin
        $display("ERR %0t: %0s quot %h, expected %h", $time, tag,
                 got[2*WIDTH-1:WIDTH], exp[2*WIDTH-1:WIDTH]);
        err_count++;
      end
      if (got[WIDTH-1:0] !== exp[WIDTH-1:0]) begin
        $display("ERR %0t: %0s rem %h, expected %h", $time, tag,
                 got[WIDTH-1:0], exp[WIDTH-1:0]);
        err_count++;
      end
    end
  end

  //--------------------------------------------------------------------------
  // APB access
  //--------------------------------------------------------------------------
  // phases change on falling edges and the response is sampled mid access phase
  task automatic apb_write(input logic [7:0] addr, input logic [WIDTH-1:0] data,
                           output logic slverr);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    #10;
    slverr = pslverr;
    if (pready !== 1'b1) begin
      $display("ERR %0t: pready %b in write access phase, expected 1", $time, pready);
      err_count++;
    end
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [WIDTH-1:0] data,
                          output logic slverr);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #10;
    data   = prdata;
    slverr = pslverr;
    if (pready !== 1'b1) begin
      $display("ERR %0t: pready %b in read access phase, expected 1", $time, pready);
      err_count++;
    end
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_slverr(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: pslverr %b on %0s, expected %b", $time, got, what, exp);
      err_count++;
    end
  endtask

  task automatic check_word(input logic [WIDTH-1:0] got, input logic [WIDTH-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("ERR %0t: %0s read %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  //--------------------------------------------------------------------------
  // division sequences
  //--------------------------------------------------------------------------
  task automatic start_div(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                           input logic is_signed);
    logic             err;
    logic [WIDTH-1:0] ctrl;
    ctrl = '0;
    ctrl[ctrl_start_bit]  = 1'b1;
    ctrl[ctrl_signed_bit] = is_signed;
    apb_write(reg_opa, a, err);
    check_slverr(err, 1'b0, "opa write");
    apb_write(reg_opb, b, err);
    check_slverr(err, 1'b0, "opb write");
    apb_write(reg_ctrl, ctrl, err);
    check_slverr(err, 1'b0, "start write");
  endtask

  // poll status until done or the read limit runs out
  task automatic poll_done(output logic ok);
    logic [WIDTH-1:0] st;
    logic             err;
    int               polls;
    ok    = 1'b0;
    polls = 0;
    while (!ok && polls < max_polls) begin
      apb_read(reg_status, st, err);
      check_slverr(err, 1'b0, "status read");
      ok = st[status_done_bit];
      polls++;
    end
    if (!ok) begin
      $display("timeout in %0s: done never set after %0d status reads", cur_test, polls);
      err_count++;
    end
  endtask

  // read both results and hand them to the compare process
  task automatic read_results(input logic [2*WIDTH-1:0] exp, input string tag);
    logic [WIDTH-1:0] q;
    logic [WIDTH-1:0] r;
    logic             err;
    apb_read(reg_quot, q, err);
    check_slverr(err, 1'b0, "quot read");
    apb_read(reg_rem, r, err);
    check_slverr(err, 1'b0, "rem read");
    got_q.push_back({q, r});
    exp_q.push_back(exp);
    tag_q.push_back(tag);
    -> result_ready;
  endtask

  task automatic finish_div(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                            input logic is_signed, input string tag);
    logic ok;
    poll_done(ok);
    if (ok) begin
      read_results(ref_div(a, b, is_signed), tag);
    end
  endtask

  task automatic run_div(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                         input logic is_signed, input string tag);
    start_div(a, b, is_signed);
    finish_div(a, b, is_signed, tag);
  endtask

  //--------------------------------------------------------------------------
  // test bookkeeping
  //--------------------------------------------------------------------------
  task automatic open_test(input string name);
    cur_test  = name;
    test_errs = err_count;
  endtask

  task automatic drain_checker;
    int waits;
    waits = 0;
    while (got_q.size() > 0 && waits < 10) begin
      #1;
      waits++;
    end
    if (got_q.size() > 0) begin
      $display("compare process left %0d results unchecked", got_q.size());
      err_count++;
    end
  endtask

  task automatic close_test;
    drain_checker();
    test_count++;
    if (err_count == test_errs) begin
      $display("test %0s: pass", cur_test);
    end else begin
      fail_count++;
      $display("test %0s: fail, %0d errors", cur_test, err_count - test_errs);
    end
  endtask

  //--------------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------------
  initial begin : stimulus
    logic [WIDTH-1:0] rd;
    logic [WIDTH-1:0] exp_st;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic [31:0]      rnd;
    logic             err;
    clk        = 1'b0;
    reset      = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    seed       = 32'he0cc;
    err_count  = 0;
    test_count = 0;
    fail_count = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // idle after reset with nothing pending and no read errors
    open_test("reset_state");
    apb_read(reg_status, rd, err);
    check_word(rd, '0, "status");
    check_slverr(err, 1'b0, "status read");
    apb_read(reg_ctrl, rd, err);
    check_word(rd, '0, "ctrl");
    check_slverr(err, 1'b0, "ctrl read");
    apb_read(8'h20, rd, err);
    check_word(rd, '0, "unmapped");
    check_slverr(err, 1'b0, "unmapped read");
    close_test();

    open_test("unsigned_directed");
    run_div(32'd100, 32'd10, 1'b0, "100/10");
    run_div(32'd5, 32'd7, 1'b0, "5/7");
    run_div(32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, "ones/ones");
    run_div(32'hFFFF_FFFF, 32'd1, 1'b0, "ones/1");
    run_div(32'hFFFF_FFFF, 32'd16, 1'b0, "ones/16");
    run_div(32'd1234, 32'd0, 1'b0, "1234/0");
    run_div(32'd0, 32'd5, 1'b0, "0/5");
    close_test();

    // remainder follows the dividend sign
    open_test("signed_directed");
    run_div(32'd100, 32'd7, 1'b1, "+100/+7");
    run_div(-32'd100, 32'd7, 1'b1, "-100/+7");
    run_div(32'd100, -32'd7, 1'b1, "+100/-7");
    run_div(-32'd100, -32'd7, 1'b1, "-100/-7");
    run_div(32'h8000_0000, 32'hFFFF_FFFF, 1'b1, "min/-1");
    run_div(-32'd7, 32'd0, 1'b1, "-7/0");
    close_test();

    // second start is refused and an operand change after load has no effect
    open_test("start_while_busy");
    start_div(32'd1000, 32'd7, 1'b0);
    apb_write(reg_opb, 32'd3, err);
    check_slverr(err, 1'b0, "opb write while busy");
    apb_write(reg_ctrl, 32'h3, err);
    check_slverr(err, 1'b1, "start while busy");
    // refused write keeps the unsigned select
    apb_read(reg_ctrl, rd, err);
    check_word(rd, '0, "ctrl after refused start");
    apb_read(reg_status, rd, err);
    exp_st = '0;
    exp_st[status_busy_bit] = 1'b1;
    check_word(rd, exp_st, "status while busy");
    finish_div(32'd1000, 32'd7, 1'b0, "1000/7 busy");
    close_test();

    open_test("result_persist");
    run_div(32'd999, 32'd10, 1'b0, "999/10 first");
    read_results(ref_div(32'd999, 32'd10, 1'b0), "999/10 again");
    repeat (5) @(negedge clk);
    apb_read(reg_status, rd, err);
    exp_st = '0;
    exp_st[status_done_bit] = 1'b1;
    check_word(rd, exp_st, "status held done");
    read_results(ref_div(32'd999, 32'd10, 1'b0), "999/10 late");
    // new start clears done
    start_div(32'd77, 32'd5, 1'b0);
    apb_read(reg_status, rd, err);
    exp_st = '0;
    exp_st[status_busy_bit] = 1'b1;
    check_word(rd, exp_st, "status after new start");
    finish_div(32'd77, 32'd5, 1'b0, "77/5");
    close_test();

    // random operands, shortened divisors and a few zeros
    open_test("random");
    for (int i = 0; i < 200; i++) begin
      a   = $random(seed);
      b   = $random(seed);
      rnd = $random(seed);
      b   = b >> rnd[12:8];
      if (rnd[5:0] == 6'd0) begin
        b = '0;
      end
      run_div(a, b, rnd[16], "random");
    end
    close_test();

    $display("%0d tests, %0d failed, %0d errors", test_count, fail_count, err_count);
    if (err_count == 0 && fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
source/div_pkg.sv
source/div_req_if.sv
source/div_resp_if.sv
source/div_ctrl_if.sv
source/div_apb_regs.sv
source/div_iter_ctrl.sv
source/div_iter_dpath.sv
source/div_result_buf.sv
source/div_apb_top.sv
verif/div_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the divider testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --timescale 1ns/1ps \
  --top-module div_tb -f filelist.f -o div_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/div_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# any failure report in the log fails the run
if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
